// File: include/fe_consts.svh
`ifndef FE_CONSTS_SVH
`define FE_CONSTS_SVH

// bundle shape
`define FE_LANES 4
`define FE_INSTR_W 32
`define FE_INSTR_BYTES 4

// instruction fields
`define FE_REG_W 6
`define FE_IMM_W 10

// decoded constant and addresses
`define FE_DATA_W 32
`define FE_IP_W 48

// fetch-miss request
`define FE_REQ_ADDR_W 38
`define FE_SLOT_W 10

`endif

// File: src/fe_pkg.sv
`include "fe_consts.svh"

package fe_pkg;

  typedef enum logic [3:0] {
    OP_NOP = 4'd0,
    OP_ADD = 4'd1,
    OP_SUB = 4'd2,
    OP_AND = 4'd3,
    OP_OR = 4'd4,
    OP_XOR = 4'd5,
    OP_SHL = 4'd6,
    OP_ADDI = 4'd7,
    OP_LOAD = 4'd8,
    OP_STORE = 4'd9,
    OP_BRANCH = 4'd10,
    OP_JUMP = 4'd11,
    OP_ILLEGAL = 4'd15
  } op_e;

  // reservation station port
  typedef enum logic [1:0] {
    PORT_ALU = 2'd0,
    PORT_SHIFT = 2'd1,
    PORT_MEM = 2'd2,
    PORT_BRANCH = 2'd3
  } port_e;

  typedef struct packed {
    logic valid;
    logic [`FE_LANES-1:0] mask;
    logic [`FE_LANES-1:0][`FE_INSTR_W-1:0] instr;
    logic [`FE_IP_W-1:0] base;
  } fetch_bundle_t;

  typedef struct packed {
    logic en;
    logic tlb_en;
    logic [`FE_REQ_ADDR_W-1:0] addr;
    logic [`FE_SLOT_W-1:0] slot;
  } fetch_req_t;

  typedef struct packed {
    op_e op;
    port_e port;
    logic [`FE_REG_W-1:0] rt;
    logic [`FE_REG_W-1:0] ra;
    logic [`FE_REG_W-1:0] rb;
    logic rt_use;
    logic ra_use;
    logic rb_use;
    logic use_const;
    logic [`FE_DATA_W-1:0] const_val;
  } dec_op_t;

  typedef struct packed {
    logic valid;
    logic thread;
    logic [`FE_LANES-1:0] lane_en;
    dec_op_t [`FE_LANES-1:0] ops;
    logic [`FE_LANES-1:0][`FE_IP_W-1:0] lane_ip;
    logic jump_any;
    logic [$clog2(`FE_LANES)-1:0] jump_pos;
  } issue_bundle_t;

endpackage

// File: src/thread_arbiter.sv
`timescale 1ns/1ps

module thread_arbiter (
  input  logic clk,
  input  logic rst,
  input  logic stall,
  input  logic valid0,
  input  logic valid1,
  output logic take0,
  output logic take1,
  output logic thread
);

  // a lone valid thread gets the next slot, otherwise alternate
  always_ff @(posedge clk) begin
    if (rst) begin
      thread <= 1'b0;
    end else if (valid0 && !valid1) begin
      thread <= 1'b0;
    end else if (valid1 && !valid0) begin
      thread <= 1'b1;
    end else begin
      thread <= !thread;
    end
  end

  // no bundle may leave its thread while in reset
  always_comb begin
    take0 = 1'b0;
    take1 = 1'b0;
    if (!rst && !stall) begin
      take0 = !thread && valid0;
      take1 = thread && valid1;
    end
  end

endmodule

// File: src/fetch_req_arbiter.sv
`timescale 1ns/1ps

module fetch_req_arbiter
  import fe_pkg::*;
(
  input  logic       clk,
  input  logic       rst,
  input  fetch_req_t req0,
  input  fetch_req_t req1,
  output fetch_req_t req_out
);

  fetch_req_t sel;

  // thread 0 wins on either a miss or a tlb request
  assign sel = (req0.en || req0.tlb_en) ? req0 : req1;

  always_ff @(posedge clk) begin
    if (rst) begin
      req_out.en <= 1'b0;
      req_out.tlb_en <= 1'b0;
    end else begin
      req_out.en <= sel.en;
      req_out.tlb_en <= sel.tlb_en;
    end
    req_out.addr <= sel.addr;
    req_out.slot <= sel.slot;
  end

endmodule

// File: src/lane_decoder.sv
`timescale 1ns/1ps
`include "fe_consts.svh"

module lane_decoder
  import fe_pkg::*;
(
  input  logic [`FE_INSTR_W-1:0] instr,
  output dec_op_t                op
);

  localparam int OP_W = $bits(op_e);
  localparam int RB_LSB = `FE_IMM_W;
  localparam int RA_LSB = `FE_IMM_W + `FE_REG_W;
  localparam int RT_LSB = `FE_IMM_W + 2 * `FE_REG_W;

  op_e opc;
  logic [`FE_IMM_W-1:0] imm;

  assign imm = instr[`FE_IMM_W-1:0];

  // codes 12 to 14 are unassigned
  always_comb begin
    opc = op_e'(instr[`FE_INSTR_W-1 -: OP_W]);
    if (instr[`FE_INSTR_W-1 -: OP_W] inside {4'd12, 4'd13, 4'd14}) begin
      opc = OP_ILLEGAL;
    end
  end

  always_comb begin
    op = '0;
    op.op = opc;
    op.rt = instr[RT_LSB +: `FE_REG_W];
    op.ra = instr[RA_LSB +: `FE_REG_W];
    op.rb = instr[RB_LSB +: `FE_REG_W];

    case (opc)
      OP_SHL: begin
        op.port = PORT_SHIFT;
      end
      OP_LOAD, OP_STORE: begin
        op.port = PORT_MEM;
      end
      OP_BRANCH, OP_JUMP: begin
        op.port = PORT_BRANCH;
      end
      default: begin
        op.port = PORT_ALU;
      end
    endcase

    op.ra_use = !(opc inside {OP_NOP, OP_JUMP, OP_ILLEGAL});
    op.rb_use = opc inside {OP_ADD, OP_SUB, OP_AND, OP_OR, OP_XOR, OP_SHL, OP_STORE};
    op.rt_use = opc inside {OP_ADD, OP_SUB, OP_AND, OP_OR, OP_XOR, OP_SHL, OP_ADDI,
                            OP_LOAD};
    op.use_const = opc inside {OP_ADDI, OP_LOAD, OP_STORE, OP_BRANCH, OP_JUMP};

    // sign-extended immediate or zero when unused
    if (op.use_const) begin
      op.const_val = {{(`FE_DATA_W - `FE_IMM_W){imm[`FE_IMM_W-1]}}, imm};
    end else begin
      op.const_val = '0;
    end
  end

endmodule

// File: src/issue_register.sv
`timescale 1ns/1ps
`include "fe_consts.svh"

module issue_register
  import fe_pkg::*;
(
  input  logic                     clk,
  input  logic                     rst,
  input  logic                     take,
  input  logic                     thread,
  input  fetch_bundle_t            bundle,
  input  dec_op_t [`FE_LANES-1:0]  ops,
  output issue_bundle_t            issue
);

  localparam int POS_W = $clog2(`FE_LANES);

  logic [`FE_LANES-1:0] lane_en;
  logic [`FE_LANES-1:0][`FE_IP_W-1:0] lane_ip;
  logic jump_any;
  logic [POS_W-1:0] jump_pos;

  // lanes after the first valid branch or jump are cut off
  always_comb begin
    lane_en = '0;
    jump_any = 1'b0;
    jump_pos = '0;
    for (int i = 0; i < `FE_LANES; i++) begin
      if (bundle.mask[i] && !jump_any) begin
        lane_en[i] = 1'b1;
        if (ops[i].op inside {OP_BRANCH, OP_JUMP}) begin
          jump_any = 1'b1;
          jump_pos = POS_W'(i);
        end
      end
    end
  end

  always_comb begin
    for (int i = 0; i < `FE_LANES; i++) begin
      lane_ip[i] = bundle.base + `FE_IP_W'(i * `FE_INSTR_BYTES);
    end
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      issue.valid <= 1'b0;
    end else begin
      issue.valid <= take;
    end
    issue.thread <= thread;
    issue.lane_en <= lane_en;
    issue.ops <= ops;
    issue.lane_ip <= lane_ip;
    issue.jump_any <= jump_any;
    issue.jump_pos <= jump_pos;
  end

endmodule

// File: src/dual_thread_frontend.sv
`timescale 1ns/1ps
`include "fe_consts.svh"

module dual_thread_frontend
  import fe_pkg::*;
(
  input  logic          clk,
  input  logic          rst,
  input  logic          stall,
  input  fetch_bundle_t fetch0,
  input  fetch_bundle_t fetch1,
  output logic          take0,
  output logic          take1,
  input  fetch_req_t    req0,
  input  fetch_req_t    req1,
  output fetch_req_t    req_out,
  output issue_bundle_t issue
);

  logic thread;
  fetch_bundle_t sel_bundle;
  dec_op_t [`FE_LANES-1:0] ops;

  thread_arbiter u_thread_arb (
    .clk    (clk),
    .rst    (rst),
    .stall  (stall),
    .valid0 (fetch0.valid),
    .valid1 (fetch1.valid),
    .take0  (take0),
    .take1  (take1),
    .thread (thread)
  );

  fetch_req_arbiter u_req_arb (
    .clk     (clk),
    .rst     (rst),
    .req0    (req0),
    .req1    (req1),
    .req_out (req_out)
  );

  // decoders always look at the thread currently being served
  assign sel_bundle = thread ? fetch1 : fetch0;

  for (genvar i = 0; i < `FE_LANES; i++) begin : g_lane
    lane_decoder u_dec (
      .instr (sel_bundle.instr[i]),
      .op    (ops[i])
    );
  end

  issue_register u_issue (
    .clk    (clk),
    .rst    (rst),
    .take   (take0 | take1),
    .thread (thread),
    .bundle (sel_bundle),
    .ops    (ops),
    .issue  (issue)
  );

endmodule

// File: bench/tb_dual_thread_frontend.sv
`timescale 1ns/1ps
`include "fe_consts.svh"

module tb_dual_thread_frontend
  import fe_pkg::*;
();

  localparam int CLK_PERIOD = 10;
  localparam int RESET_CYCLES = 10;
  localparam int MODE_SWEEP = 0;
  localparam int MODE_BRANCH = 1;
  localparam int MODE_RANDOM = 2;
  localparam int SWEEP_CYCLES = 40;
  localparam int BRANCH_CYCLES = 120;
  localparam int RANDOM_CYCLES = 200;
  localparam int STALL_CYCLES = 12;
  localparam int TAIL_CYCLES = 40;
  localparam int TEST_CYCLES = RESET_CYCLES + 3 + SWEEP_CYCLES + BRANCH_CYCLES
                               + RANDOM_CYCLES + STALL_CYCLES + TAIL_CYCLES;
  localparam int WD_MARGIN = 50;
  localparam int POS_W = $clog2(`FE_LANES);

  logic clk = 1'b0;
  logic rst;
  logic stall;
  fetch_bundle_t fetch0;
  fetch_bundle_t fetch1;
  logic take0;
  logic take1;
  fetch_req_t req0;
  fetch_req_t req1;
  fetch_req_t req_out;
  issue_bundle_t issue;

  logic [31:0] rng_state = 32'hc5879361;
  int sweep_idx = 0;
  int errors = 0;

  // reference model state advanced at each falling edge
  logic model_thread = 1'b0;
  logic exp_take0;
  logic exp_take1;
  logic took0 = 1'b0;
  logic took1 = 1'b0;
  issue_bundle_t exp_issue = '0;
  fetch_req_t exp_req = '0;

  dual_thread_frontend u_dut (
    .clk     (clk),
    .rst     (rst),
    .stall   (stall),
    .fetch0  (fetch0),
    .fetch1  (fetch1),
    .take0   (take0),
    .take1   (take1),
    .req0    (req0),
    .req1    (req1),
    .req_out (req_out),
    .issue   (issue)
  );

  always #(CLK_PERIOD / 2) clk = !clk;

  function automatic logic [31:0] next_rand();
    rng_state = rng_state * 32'd1664525 + 32'd1013904223;
    return rng_state;
  endfunction

  function automatic dec_op_t ref_decode(logic [`FE_INSTR_W-1:0] w);
    dec_op_t d;
    int code;
    d = '0;
    code = w[31:28];
    if (code >= 12 && code <= 14) begin
      code = 15;
    end
    d.op = op_e'(code);
    d.rt = w[27:22];
    d.ra = w[21:16];
    d.rb = w[15:10];
    d.ra_use = !(code == 0 || code == 11 || code == 15);
    d.rb_use = (code >= 1 && code <= 6) || code == 9;
    d.rt_use = code >= 1 && code <= 8;
    d.use_const = code >= 7 && code <= 11;
    if (code == 6) begin
      d.port = PORT_SHIFT;
    end else if (code == 8 || code == 9) begin
      d.port = PORT_MEM;
    end else if (code == 10 || code == 11) begin
      d.port = PORT_BRANCH;
    end else begin
      d.port = PORT_ALU;
    end
    if (d.use_const) begin
      d.const_val = {{(`FE_DATA_W - `FE_IMM_W){w[`FE_IMM_W-1]}}, w[`FE_IMM_W-1:0]};
    end
    return d;
  endfunction

  function automatic issue_bundle_t ref_issue(logic thr, fetch_bundle_t b);
    issue_bundle_t r;
    logic cut;
    r = '0;
    cut = 1'b0;
    r.valid = 1'b1;
    r.thread = thr;
    for (int i = 0; i < `FE_LANES; i++) begin
      r.ops[i] = ref_decode(b.instr[i]);
      r.lane_ip[i] = b.base + `FE_IP_W'(i * `FE_INSTR_BYTES);
      if (b.mask[i] && !cut) begin
        r.lane_en[i] = 1'b1;
        // only branches and jumps go to the branch port
        if (r.ops[i].port == PORT_BRANCH) begin
          cut = 1'b1;
          r.jump_any = 1'b1;
          r.jump_pos = POS_W'(i);
        end
      end
    end
    return r;
  endfunction

  function automatic logic ref_thread(logic cur, logic v0, logic v1);
    case ({v1, v0})
      2'b01: return 1'b0;
      2'b10: return 1'b1;
      default: return !cur;
    endcase
  endfunction

  function automatic fetch_req_t ref_req(fetch_req_t a, fetch_req_t b);
    if (a.en || a.tlb_en) begin
      return a;
    end
    return b;
  endfunction

  function automatic fetch_bundle_t make_bundle(int mode, logic thr);
    fetch_bundle_t b;
    logic [31:0] r;
    logic [31:0] hi;
    b = '0;
    hi = next_rand();
    b.base = {hi[15:0], next_rand()};
    for (int i = 0; i < `FE_LANES; i++) begin
      r = next_rand();
      b.instr[i] = next_rand();
      if (mode == MODE_SWEEP) begin
        b.instr[i][31:28] = 4'((sweep_idx + i) % 16);
      end else if (mode == MODE_BRANCH) begin
        if (r[3:0] < 4'd3) begin
          b.instr[i][31:28] = 4'd10 + r[4];
        end else begin
          b.instr[i][31:28] = 4'd1 + r[7:5];
        end
      end
    end
    r = next_rand();
    if (mode == MODE_SWEEP) begin
      b.valid = !thr;
      b.mask = '1;
      if (!thr) begin
        sweep_idx++;
      end
    end else if (mode == MODE_BRANCH) begin
      b.valid = r[9:8] != 2'b00;
      b.mask = r[13:10];
    end else begin
      b.valid = r[20];
      b.mask = r[24:21];
    end
    return b;
  endfunction

  function automatic fetch_req_t make_req();
    fetch_req_t q;
    logic [31:0] r;
    logic [31:0] hi;
    r = next_rand();
    hi = next_rand();
    q.en = r[31];
    q.tlb_en = r[30];
    q.slot = r[9:0];
    q.addr = {hi[5:0], next_rand()};
    return q;
  endfunction

  task automatic abort_run(string why);
    errors++;
    $display("TESTBENCH FAILED");
    $fatal(1, why);
  endtask

  task automatic check_take(string name, logic got, logic exp);
    if (got !== exp) begin
      $display("ERROR %s: got %h, expected %h", name, got, exp);
      abort_run("take signal mismatch");
    end
  endtask

  task automatic check_issue(issue_bundle_t got, issue_bundle_t exp);
    if (exp.valid && got !== exp) begin
      $display("ERROR issue: got %h, expected %h", got, exp);
      abort_run("issue bundle mismatch");
    end else if (!exp.valid && got.valid !== 1'b0) begin
      $display("ERROR issue.valid: got %h, expected %h", got.valid, exp.valid);
      abort_run("issue valid mismatch");
    end
  endtask

  task automatic check_req(fetch_req_t got, fetch_req_t exp);
    if (got !== exp) begin
      $display("ERROR req_out: got %h, expected %h", got, exp);
      abort_run("fetch request mismatch");
    end
  endtask

  // inputs are held from 1 ns after the rising edge, so the falling edge is stable
  always @(negedge clk) begin
    if (rst) begin
      check_take("take0", take0, 1'b0);
      check_take("take1", take1, 1'b0);
      model_thread = 1'b0;
      exp_issue = '0;
      exp_req = '0;
      took0 = 1'b0;
      took1 = 1'b0;
    end else begin
      exp_take0 = !stall && !model_thread && fetch0.valid;
      exp_take1 = !stall && model_thread && fetch1.valid;
      check_take("take0", take0, exp_take0);
      check_take("take1", take1, exp_take1);
      check_issue(issue, exp_issue);
      check_req(req_out, exp_req);
      if (exp_take0 || exp_take1) begin
        exp_issue = ref_issue(model_thread, model_thread ? fetch1 : fetch0);
      end else begin
        exp_issue = '0;
      end
      exp_req = ref_req(req0, req1);
      took0 = exp_take0;
      took1 = exp_take1;
      model_thread = ref_thread(model_thread, fetch0.valid, fetch1.valid);
    end
  end

  // a thread keeps its bundle until it was taken
  task automatic run_phase(int mode, int cycles, int stall_pct);
    repeat (cycles) begin
      @(posedge clk);
      #1;
      if (!fetch0.valid || took0) begin
        fetch0 = make_bundle(mode, 1'b0);
      end
      if (!fetch1.valid || took1) begin
        fetch1 = make_bundle(mode, 1'b1);
      end
      stall = int'(next_rand() % 100) < stall_pct;
      req0 = make_req();
      req1 = make_req();
    end
  endtask

  initial begin
    #((TEST_CYCLES + WD_MARGIN) * CLK_PERIOD);
    abort_run("watchdog timeout, the test did not finish in time");
  end

  initial begin
    rst = 1'b1;
    stall = 1'b0;
    fetch0 = '0;
    fetch1 = '0;
    // offers during reset must not be taken
    fetch0.valid = 1'b1;
    fetch1.valid = 1'b1;
    req0 = '0;
    req1 = '0;
    repeat (RESET_CYCLES) @(posedge clk);
    #1;
    rst = 1'b0;
    fetch0 = make_bundle(MODE_BRANCH, 1'b0);
    fetch0.valid = 1'b1;
    fetch1 = make_bundle(MODE_BRANCH, 1'b1);
    fetch1.valid = 1'b1;
    @(negedge clk);
    if (!take0 || take1) begin
      abort_run("first take after reset did not go to thread 0");
    end
    run_phase(MODE_SWEEP, SWEEP_CYCLES, 0);
    run_phase(MODE_BRANCH, BRANCH_CYCLES, 0);
    run_phase(MODE_RANDOM, RANDOM_CYCLES, 15);
    run_phase(MODE_BRANCH, STALL_CYCLES, 100);
    run_phase(MODE_RANDOM, TAIL_CYCLES, 0);
    repeat (2) @(posedge clk);
    @(negedge clk);
    if (errors == 0) begin
      $display("TESTBENCH PASSED");
    end else begin
      $display("TESTBENCH FAILED");
    end
    $finish;
  end

endmodule

// File: dual_thread_frontend.f
+incdir+include
src/fe_pkg.sv
src/thread_arbiter.sv
src/fetch_req_arbiter.sv
src/lane_decoder.sv
src/issue_register.sv
src/dual_thread_frontend.sv
bench/tb_dual_thread_frontend.sv

// File: Bender.yml
package:
  name: dual_thread_frontend

export_include_dirs:
  - include

sources:
  - files:
      - src/fe_pkg.sv
      - src/thread_arbiter.sv
      - src/fetch_req_arbiter.sv
      - src/lane_decoder.sv
      - src/issue_register.sv
      - src/dual_thread_frontend.sv
  - target: test
    files:
      - bench/tb_dual_thread_frontend.sv
